// File: run.sh
#!/usr/bin/env bash
# build and run the load unit testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module load_unit_tb -f sim.f -o load_unit_sim \
    && ./obj_dir/load_unit_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

// File: sim.f
+incdir+source
source/load_pkg.sv
source/load_req_queue.sv
source/axi_read_master.sv
source/load_align.sv
source/load_unit_top.sv
test/axi_mem_responder.sv
test/load_unit_tb.sv

// File: source/axi_read_master.sv
`timescale 1ns/1ns
`default_nettype none
`include "load_config.svh"

module axi_read_master (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      nonempty_i,
    input  wire load_pkg::load_req_t head_i,
    output logic                     pop_o,
    output logic                     ar_valid_o,
    output load_pkg::axi_ar_t        ar_o,
    input  wire                      ar_ready_i,
    input  wire                      r_valid_i,
    input  wire load_pkg::axi_r_t    r_i,
    output logic                     r_ready_o,
    output logic                     done_o,
    output load_pkg::beat_t          beat_o
);

    // read channel states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_read = 2'd2;

    // byte offset bits inside one beat
    localparam int unsigned off_w = $clog2(`LOAD_DATA_W / 8);
    // AxSIZE code for a full-width beat
    localparam logic [2:0] beat_size = 3'(off_w);

    logic [1:0]          state;
    // request in flight, held until the beat returns
    load_pkg::load_req_t req_q;
    logic                ar_hs;
    logic                r_hs;
    logic                done_q;
    load_pkg::beat_t     beat_q;

    assign ar_hs = ar_valid_o & ar_ready_i;
    assign r_hs  = r_valid_i & r_ready_o;

    // pop strobe as idle is left
    assign pop_o      = (state == st_idle) & nonempty_i;
    assign ar_valid_o = state == st_addr;
    assign r_ready_o  = state == st_read;

    // aligned single-beat read
    assign ar_o = '{
        addr: {req_q.addr[`LOAD_ADDR_W-1:off_w], {off_w{1'b0}}},
        size: beat_size,
        len:  8'd0
    };

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (nonempty_i) state <= st_addr;
                st_addr: if (ar_hs) state <= st_read;
                st_read: if (r_hs) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // latch the head on pop
    always_ff @(posedge clock) begin
        if (pop_o) begin
            req_q <= head_i;
        end
    end

    // beat and response travel with their request
    always_ff @(posedge clock) begin
        if (r_hs) begin
            beat_q.data <= r_i.data;
            beat_q.resp <= r_i.resp;
            beat_q.req  <= req_q;
        end
    end

    // done one cycle after the R handshake
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= r_hs;
        end
    end

    assign done_o = done_q;
    assign beat_o = beat_q;

    // len is 0, so the slave must close every burst at once
    r_last_each_beat: assert property (@(posedge clock) disable iff (!reset_n)
        r_hs |-> r_i.last);

    // AR must not change while the slave stalls
    ar_held_stable: assert property (@(posedge clock) disable iff (!reset_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

endmodule

`default_nettype wire

// File: source/load_align.sv
`timescale 1ns/1ns
`default_nettype none
`include "load_config.svh"

module load_align (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   done_i,
    input  wire load_pkg::beat_t  beat_i,
    output logic                  rsp_valid_o,
    output load_pkg::load_rsp_t   rsp_o
);

    // beat decoded as lanes
    load_pkg::load_beat_u    view;
    // byte offset of the access in the beat
    logic [2:0]              offset;
    logic [7:0]              byte_f;
    logic [15:0]             half_f;
    logic [31:0]             word_f;
    logic [`LOAD_DATA_W-1:0] ext;
    logic                    rsp_valid_q;
    load_pkg::load_rsp_t     rsp_q;

    assign view   = beat_i.data;
    assign offset = beat_i.req.addr[2:0];

    // lane select, low offset bits ignored for wider sizes
    assign byte_f = view.byte_v[offset];
    assign half_f = view.half_v[offset[2:1]];
    assign word_f = view.word_v[offset[2]];

    // sign or zero fill above the field
    always_comb begin
        case (beat_i.req.size)
            load_pkg::size_byte: begin
                ext = {{(`LOAD_DATA_W - 8){beat_i.req.sign & byte_f[7]}}, byte_f};
            end
            load_pkg::size_half: begin
                ext = {{(`LOAD_DATA_W - 16){beat_i.req.sign & half_f[15]}}, half_f};
            end
            load_pkg::size_word: begin
                ext = {{(`LOAD_DATA_W - 32){beat_i.req.sign & word_f[31]}}, word_f};
            end
            default: begin
                // double takes the whole beat, sign is moot
                ext = beat_i.data;
            end
        endcase
    end

    // result register, loaded on done
    always_ff @(posedge clock) begin
        if (done_i) begin
            rsp_q.data <= ext;
            // error responses still carry data
            rsp_q.resp <= beat_i.resp;
        end
    end

    // valid trails done by one cycle
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= done_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: source/load_config.svh
`ifndef LOAD_CONFIG_SVH
`define LOAD_CONFIG_SVH

// core-side byte address
`define LOAD_ADDR_W 32

// one AXI read beat
`define LOAD_DATA_W 64

// request queue entries
`define LOAD_QUEUE_DEPTH 4

`endif

// File: source/load_pkg.sv
`default_nettype none
`include "load_config.svh"

package load_pkg;

    // access size of a core load
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } load_size_e;

    // one core load request
    typedef struct packed {
        logic [`LOAD_ADDR_W-1:0] addr;
        load_size_e              size;
        // set for lb/lh/lw, clear for the unsigned forms
        logic                    sign;
    } load_req_t;

    // AR payload, only the fields that vary
    typedef struct packed {
        logic [`LOAD_ADDR_W-1:0] addr;
        logic [2:0]              size;
        logic [7:0]              len;
    } axi_ar_t;

    // R payload
    typedef struct packed {
        logic [`LOAD_DATA_W-1:0] data;
        logic [1:0]              resp;
        logic                    last;
    } axi_r_t;

    // one beat seen as bytes, halfwords or words
    typedef union packed {
        logic [7:0][7:0]  byte_v;
        logic [3:0][15:0] half_v;
        logic [1:0][31:0] word_v;
    } load_beat_u;

    // extended load result with the bus response
    typedef struct packed {
        logic [`LOAD_DATA_W-1:0] data;
        logic [1:0]              resp;
    } load_rsp_t;

    // captured beat plus the request it answers
    typedef struct packed {
        logic [`LOAD_DATA_W-1:0] data;
        logic [1:0]              resp;
        load_req_t               req;
    } beat_t;

endpackage

`default_nettype wire

// File: source/load_req_queue.sv
`timescale 1ns/1ns
`default_nettype none
`include "load_config.svh"

module load_req_queue (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      push_i,
    input  wire load_pkg::load_req_t req_i,
    input  wire                      pop_i,
    output logic                     full_o,
    output logic                     nonempty_o,
    output load_pkg::load_req_t      head_o
);

    localparam int unsigned depth = `LOAD_QUEUE_DEPTH;
    localparam int unsigned ptr_w = $clog2(depth);
    localparam int unsigned cnt_w = $clog2(depth + 1);

    // payload storage
    load_pkg::load_req_t entries [depth];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic                push_ok;
    logic                pop_ok;
    // last byte touched, relative to the 8-byte line
    logic [3:0]          size_span;
    logic [3:0]          end_byte;

    // wrap for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a push into a full queue is dropped
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & nonempty_o;

    always_ff @(posedge clock) begin
        if (push_ok) begin
            entries[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign full_o     = count == cnt_w'(depth);
    assign nonempty_o = count != '0;
    // head shows a fresh push one cycle later
    assign head_o     = entries[rd_ptr];

    // bytes beyond the first, per size
    always_comb begin
        case (req_i.size)
            load_pkg::size_byte: size_span = 4'd0;
            load_pkg::size_half: size_span = 4'd1;
            load_pkg::size_word: size_span = 4'd3;
            default:             size_span = 4'd7;
        endcase
    end

    assign end_byte = {1'b0, req_i.addr[2:0]} + size_span;

    // core must watch full_o before pushing
    push_not_full: assert property (@(posedge clock) disable iff (!reset_n)
        push_i |-> !full_o);

    // master only pops what it saw as present
    pop_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop_i |-> nonempty_o);

    // one beat per load, so no access may spill past the line
    push_in_line: assert property (@(posedge clock) disable iff (!reset_n)
        push_i |-> !end_byte[3]);

endmodule

`default_nettype wire

// File: source/load_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module load_unit_top (
    input  wire                      clock,
    input  wire                      reset_n,
    // core request side
    input  wire                      push_i,
    input  wire load_pkg::load_req_t req_i,
    output logic                     full_o,
    // AXI read address
    output logic                     ar_valid_o,
    output load_pkg::axi_ar_t        ar_o,
    input  wire                      ar_ready_i,
    // AXI read data
    input  wire                      r_valid_i,
    input  wire load_pkg::axi_r_t    r_i,
    output logic                     r_ready_o,
    // core result side
    output logic                     rsp_valid_o,
    output load_pkg::load_rsp_t      rsp_o
);

    // queue to master
    logic                nonempty;
    logic                pop;
    load_pkg::load_req_t head;
    // master to align stage
    logic                done;
    load_pkg::beat_t     beat;

    load_req_queue u_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .push_i     (push_i),
        .req_i      (req_i),
        .pop_i      (pop),
        .full_o     (full_o),
        .nonempty_o (nonempty),
        .head_o     (head)
    );

    axi_read_master u_master (
        .clock      (clock),
        .reset_n    (reset_n),
        .nonempty_i (nonempty),
        .head_i     (head),
        .pop_o      (pop),
        .ar_valid_o (ar_valid_o),
        .ar_o       (ar_o),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .r_i        (r_i),
        .r_ready_o  (r_ready_o),
        .done_o     (done),
        .beat_o     (beat)
    );

    load_align u_align (
        .clock       (clock),
        .reset_n     (reset_n),
        .done_i      (done),
        .beat_i      (beat),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

// File: test/axi_mem_responder.sv
`timescale 1ns/1ns
`default_nettype none
`include "load_config.svh"

module axi_mem_responder (
    input  wire                    clock,
    input  wire                    reset_n,
    // keeps ar_ready low while set
    input  wire                    hold_ar_i,
    input  wire                    ar_valid_i,
    input  wire load_pkg::axi_ar_t ar_i,
    output logic                   ar_ready_o,
    output logic                   r_valid_o,
    output load_pkg::axi_r_t       r_o,
    input  wire                    r_ready_i
);

    integer                  seed;
    logic [31:0]             rnd;
    // cycles left before the next ready or valid
    logic [1:0]              delay;
    logic                    in_read;
    logic [`LOAD_ADDR_W-1:0] addr_q;

    initial begin
        seed = 32'h7135cda9;
    end

    always @(posedge clock) begin
        rnd = $random(seed);
        if (!reset_n) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
            in_read    <= 1'b0;
            addr_q     <= '0;
            delay      <= rnd[1:0];
        end else if (!in_read) begin
            // address phase
            if (ar_valid_i && ar_ready_o) begin
                ar_ready_o <= 1'b0;
                addr_q     <= ar_i.addr;
                in_read    <= 1'b1;
                delay      <= rnd[1:0];
            end else if (ar_valid_i && !ar_ready_o && !hold_ar_i) begin
                if (delay == 2'd0) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    delay <= delay - 2'd1;
                end
            end
        end else begin
            // data phase, one beat per burst
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                in_read   <= 1'b0;
                delay     <= rnd[1:0];
            end else if (!r_valid_o) begin
                if (delay == 2'd0) begin
                    r_valid_o   <= 1'b1;
                    // address low, inverse high
                    r_o.data    <= {~addr_q, addr_q};
                    // top half of the map answers SLVERR
                    r_o.resp    <= addr_q[31] ? 2'd2 : 2'd0;
                    r_o.last    <= 1'b1;
                end else begin
                    delay <= delay - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/load_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "load_config.svh"

module load_unit_tb;

    // 300 loads at 12 cycles each, plus slack
    localparam int max_cycles = 300 * 12 + 100;
    localparam int depth      = `LOAD_QUEUE_DEPTH;

    logic                clock;
    logic                reset_n;
    logic                push;
    load_pkg::load_req_t req;
    logic                full;
    logic                ar_valid;
    load_pkg::axi_ar_t   ar;
    logic                ar_ready;
    logic                r_valid;
    load_pkg::axi_r_t    r;
    logic                r_ready;
    logic                rsp_valid;
    load_pkg::load_rsp_t rsp;
    logic                hold_ar;

    integer              seed;
    int                  error_count;
    int                  push_count;
    int                  rsp_count;
    int                  cycles;
    load_pkg::load_req_t rq;
    // expectations in push order
    load_pkg::load_rsp_t rsp_expect [$];
    load_pkg::axi_ar_t   ar_expect [$];

    load_unit_top UUT (
        .clock       (clock),
        .reset_n     (reset_n),
        .push_i      (push),
        .req_i       (req),
        .full_o      (full),
        .ar_valid_o  (ar_valid),
        .ar_o        (ar),
        .ar_ready_i  (ar_ready),
        .r_valid_i   (r_valid),
        .r_i         (r),
        .r_ready_o   (r_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    axi_mem_responder u_mem (
        .clock      (clock),
        .reset_n    (reset_n),
        .hold_ar_i  (hold_ar),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready)
    );

    initial begin
        clock = 1'b0;
    end

    always #10 clock = ~clock;

    // expected result from the memory rules and the extract rule
    function automatic load_pkg::load_rsp_t model_rsp(input load_pkg::load_req_t rq_m);
        logic [`LOAD_ADDR_W-1:0] base;
        logic [`LOAD_DATA_W-1:0] field;
        logic [`LOAD_DATA_W-1:0] mask;
        logic                    sbit;
        load_pkg::load_rsp_t     exp;
        base  = {rq_m.addr[`LOAD_ADDR_W-1:3], 3'b000};
        field = {~base, base} >> {rq_m.addr[2:0], 3'b000};
        case (rq_m.size)
            load_pkg::size_byte: begin
                mask = 64'hff;
                sbit = field[7];
            end
            load_pkg::size_half: begin
                mask = 64'hffff;
                sbit = field[15];
            end
            load_pkg::size_word: begin
                mask = 64'hffff_ffff;
                sbit = field[31];
            end
            default: begin
                mask = '1;
                sbit = 1'b0;
            end
        endcase
        field = field & mask;
        if (rq_m.sign && sbit) begin
            field = field | ~mask;
        end
        exp.data = field;
        exp.resp = base[31] ? 2'd2 : 2'd0;
        return exp;
    endfunction

    // one aligned 8-byte beat, single transfer
    function automatic load_pkg::axi_ar_t model_ar(input load_pkg::load_req_t rq_m);
        load_pkg::axi_ar_t exp;
        exp.addr = {rq_m.addr[`LOAD_ADDR_W-1:3], 3'b000};
        exp.size = 3'd3;
        exp.len  = 8'd0;
        return exp;
    endfunction

    task automatic check_rsp(input load_pkg::load_rsp_t got, input load_pkg::load_rsp_t exp);
        if (got !== exp) begin
            $display("Error: rsp_o got data %h resp %h, expected data %h resp %h",
                     got.data, got.resp, exp.data, exp.resp);
            error_count++;
        end
    endtask

    task automatic check_ar(input load_pkg::axi_ar_t got, input load_pkg::axi_ar_t exp);
        if (got !== exp) begin
            $display("Error: ar_o got addr %h size %h len %h, expected addr %h size %h len %h",
                     got.addr, got.size, got.len, exp.addr, exp.size, exp.len);
            error_count++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_quiet_outputs();
        check_level("rsp_valid_o", rsp_valid, 1'b0);
        check_level("ar_valid_o", ar_valid, 1'b0);
        check_level("r_ready_o", r_ready, 1'b0);
        check_level("full_o", full, 1'b0);
    endtask

    task automatic random_req(output load_pkg::load_req_t rq_o);
        logic [31:0] rnd;
        logic [2:0]  off_mask;
        rnd          = $random(seed);
        rq_o.size    = load_pkg::load_size_e'(rnd[1:0]);
        rq_o.sign    = rnd[2];
        rq_o.addr    = $random(seed);
        // natural alignment keeps the access inside one beat
        off_mask     = 3'b111 << rnd[1:0];
        rq_o.addr[2:0] = rq_o.addr[2:0] & off_mask;
    endtask

    // push only with full low and no push in the cycle before
    task automatic push_req(input load_pkg::load_req_t rq_p);
        @(negedge clock);
        while (full) begin
            @(negedge clock);
        end
        @(posedge clock);
        push <= 1'b1;
        req  <= rq_p;
        rsp_expect.push_back(model_rsp(rq_p));
        ar_expect.push_back(model_ar(rq_p));
        push_count++;
        @(posedge clock);
        push <= 1'b0;
    endtask

    task automatic drain();
        while (rsp_expect.size() != 0) begin
            @(negedge clock);
        end
        // room for a stray result
        repeat (4) @(negedge clock);
    endtask

    // outputs sampled mid-cycle
    always @(negedge clock) begin
        if (reset_n) begin
            if (ar_valid && ar_ready) begin
                if (ar_expect.size() == 0) begin
                    $display("AR handshake seen with no load pending");
                    error_count++;
                end else begin
                    check_ar(ar, ar_expect.pop_front());
                end
            end
            if (rsp_valid) begin
                rsp_count++;
                if (rsp_expect.size() == 0) begin
                    $display("rsp_valid_o pulsed with no load pending");
                    error_count++;
                end else begin
                    check_rsp(rsp, rsp_expect.pop_front());
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        seed        = 32'h7135cda9;
        error_count = 0;
        push_count  = 0;
        rsp_count   = 0;
        cycles      = 0;
        reset_n     = 1'b0;
        push        = 1'b0;
        req         = '0;
        hold_ar     = 1'b0;

        // quiet during reset
        repeat (4) begin
            @(negedge clock);
            check_quiet_outputs();
        end
        @(posedge clock);
        reset_n <= 1'b1;
        repeat (2) begin
            @(negedge clock);
            check_quiet_outputs();
        end

        // every size, both signs, every legal offset
        for (int sz = 0; sz < 4; sz++) begin
            for (int sg = 0; sg < 2; sg++) begin
                for (int off = 0; off < 8; off += (1 << sz)) begin
                    rq.addr      = $random(seed);
                    rq.addr[2:0] = off[2:0];
                    rq.size      = load_pkg::load_size_e'(sz[1:0]);
                    rq.sign      = sg[0];
                    push_req(rq);
                end
            end
        end
        drain();

        // stall AR so the queue fills behind one popped request
        @(posedge clock);
        hold_ar <= 1'b1;
        for (int k = 1; k <= depth + 1; k++) begin
            random_req(rq);
            push_req(rq);
            @(negedge clock);
            check_level("full_o", full, k == depth + 1);
        end
        @(posedge clock);
        hold_ar <= 1'b0;
        drain();

        // random mix under random slave delays
        repeat (265) begin
            random_req(rq);
            push_req(rq);
        end
        drain();

        if (rsp_count != push_count) begin
            $display("result count %0d does not match push count %0d", rsp_count, push_count);
            error_count++;
        end
        if (ar_expect.size() != 0) begin
            $display("%0d loads never issued an AR handshake", ar_expect.size());
            error_count++;
        end

        $display("pushes %0d, results %0d, errors %0d", push_count, rsp_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
